/* design/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////
// Datapath widths
////////////////////

// Instruction and pc width
`define FETCH_XLEN 32

// Instruction memory geometry
`define IMEM_DEPTH 256
`define IMEM_AW 8

////////////////////
// Special words
////////////////////

`define HALT_WORD {`FETCH_XLEN{1'b1}}
`define NOP_WORD {`FETCH_XLEN{1'b0}}

`endif

/* design/fetch_pkg.sv */
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	////////////////////
	// Data types
	////////////////////

	// Instructions and pc values
	typedef logic [`FETCH_XLEN-1:0] word_t;

	// Low pc bits that address the instruction memory
	typedef logic [`IMEM_AW-1:0] imem_addr_t;

	////////////////////
	// Enumerations
	////////////////////

	// Next pc source from the later stages
	typedef enum logic [1:0] {
		PC_SEQ      = 2'b00,
		PC_JUMP     = 2'b01,
		PC_BRANCH   = 2'b10,
		PC_REGISTER = 2'b11
	} pc_src_e;

	// Fetch stage state
	typedef enum logic {
		FETCH_RUN    = 1'b0,
		FETCH_HALTED = 1'b1
	} fetch_state_e;

endpackage

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_top
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                debug_flag,
	input  wire                load_strobe,
	input  fetch_pkg::word_t   load_word,
	input  fetch_pkg::pc_src_e pc_src,
	input  fetch_pkg::word_t   pc_jump,
	input  fetch_pkg::word_t   pc_branch,
	input  fetch_pkg::word_t   pc_register,
	input  wire                stall,
	output fetch_pkg::word_t   instr,
	output fetch_pkg::word_t   pc_next,
	output fetch_pkg::word_t   pc,
	output logic               halted
);

	logic                  wr_en;
	fetch_pkg::imem_addr_t wr_addr;
	fetch_pkg::word_t      pc_plus1;
	fetch_pkg::word_t      fetched;
	logic                  rd_en;

	// Memory reads only on enabled edges
	assign rd_en = !stall && !halted && !debug_flag;

	////////////////////
	// Program loader
	////////////////////

	imem_loader imem_loader_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.debug_flag  (debug_flag),
		.load_strobe (load_strobe),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr)
	);

	////////////////////
	// Program counter
	////////////////////

	pc_select pc_select_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.debug_flag  (debug_flag),
		.stall       (stall),
		.halted      (halted),
		.pc_src      (pc_src),
		.pc_jump     (pc_jump),
		.pc_branch   (pc_branch),
		.pc_register (pc_register),
		.pc          (pc),
		.pc_plus1    (pc_plus1)
	);

	////////////////////
	// Instruction RAM
	////////////////////

	instr_mem instr_mem_i
	(
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (load_word),
		.rd_en   (rd_en),
		.rd_addr (pc[`IMEM_AW-1:0]),
		.rd_data (fetched)
	);

	////////////////////
	// IF/ID register
	////////////////////

	if_id_reg if_id_reg_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.debug_flag (debug_flag),
		.stall      (stall),
		.pc_src     (pc_src),
		.fetched    (fetched),
		.pc_plus1   (pc_plus1),
		.instr      (instr),
		.pc_next    (pc_next),
		.halted     (halted)
	);

endmodule

`default_nettype wire

/* design/if_id_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module if_id_reg
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                debug_flag,
	input  wire                stall,
	input  fetch_pkg::pc_src_e pc_src,
	input  fetch_pkg::word_t   fetched,
	input  fetch_pkg::word_t   pc_plus1,
	output fetch_pkg::word_t   instr,
	output fetch_pkg::word_t   pc_next,
	output logic               halted
);

	fetch_pkg::fetch_state_e state;

	// Set when instr must read as a NOP
	logic nop_q;
	logic halt_seen;
	logic flush;
	logic adv;

	////////////////////
	// Halt detection
	////////////////////

	// Memory output is a real fetch holding the halt word
	assign halt_seen = !nop_q && (fetched == `HALT_WORD);

	// Raised as soon as the halt word leaves the memory
	assign halted = !debug_flag && ((state == fetch_pkg::FETCH_HALTED) || halt_seen);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= fetch_pkg::FETCH_RUN;
		end
		else if (debug_flag)
		begin
			state <= fetch_pkg::FETCH_RUN;
		end
		else if (!stall && halt_seen)
		begin
			state <= fetch_pkg::FETCH_HALTED;
		end
	end

	////////////////////
	// Decode register
	////////////////////

	assign flush = (pc_src != fetch_pkg::PC_SEQ);
	assign adv   = !debug_flag && !stall && !halted;

	// instr tracks the memory's registered output unless overridden
	assign instr = (nop_q || debug_flag) ? `NOP_WORD : fetched;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			nop_q   <= 1'b1;
			pc_next <= '0;
		end
		else if (debug_flag)
		begin
			nop_q   <= 1'b1;
			pc_next <= '0;
		end
		else if (adv)
		begin
			// Redirect squashes the word fetched at the old pc
			nop_q   <= flush;
			pc_next <= flush ? '0 : pc_plus1;
		end
	end

endmodule

`default_nettype wire

/* design/imem_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module imem_loader
(
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   debug_flag,
	input  wire                   load_strobe,
	output logic                  wr_en,
	output fetch_pkg::imem_addr_t wr_addr
);

	// Next free word of the program being loaded
	fetch_pkg::imem_addr_t load_cnt;

	////////////////////
	// Write port
	////////////////////

	// One write per strobe in debug mode
	assign wr_en   = debug_flag && load_strobe;
	assign wr_addr = load_cnt;

	////////////////////
	// Address counter
	////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load_cnt <= '0;
		end
		else if (!debug_flag)
		begin
			// Next load session starts at word zero
			load_cnt <= '0;
		end
		else if (load_strobe)
		begin
			load_cnt <= load_cnt + `IMEM_AW'd1;
		end
	end

endmodule

`default_nettype wire

/* design/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module instr_mem
(
	input  wire                   clk,
	input  wire                   wr_en,
	input  fetch_pkg::imem_addr_t wr_addr,
	input  fetch_pkg::word_t      wr_data,
	input  wire                   rd_en,
	input  fetch_pkg::imem_addr_t rd_addr,
	output fetch_pkg::word_t      rd_data
);

	// Program storage
	fetch_pkg::word_t mem [0:`IMEM_DEPTH-1];

	////////////////////
	// Debug write port
	////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////
	// Registered read
	////////////////////

	// Output holds while the stage is frozen
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* design/pc_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_select
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                debug_flag,
	input  wire                stall,
	input  wire                halted,
	input  fetch_pkg::pc_src_e pc_src,
	input  fetch_pkg::word_t   pc_jump,
	input  fetch_pkg::word_t   pc_branch,
	input  fetch_pkg::word_t   pc_register,
	output fetch_pkg::word_t   pc,
	output fetch_pkg::word_t   pc_plus1
);

	fetch_pkg::word_t pc_d;
	logic             pc_adv;

	////////////////////
	// Next address
	////////////////////

	assign pc_plus1 = pc + `FETCH_XLEN'd1;

	always_comb
	begin
		case (pc_src)
			fetch_pkg::PC_JUMP:
			begin
				pc_d = pc_jump;
			end
			fetch_pkg::PC_BRANCH:
			begin
				pc_d = pc_branch;
			end
			fetch_pkg::PC_REGISTER:
			begin
				pc_d = pc_register;
			end
			default:
			begin
				pc_d = pc_plus1;
			end
		endcase
	end

	// Enabled edge needs debug, stall and halted all low
	assign pc_adv = !debug_flag && !stall && !halted;

	////////////////////
	// Program counter
	////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= '0;
		end
		else if (debug_flag)
		begin
			// Program restarts from word zero after loading
			pc <= '0;
		end
		else if (pc_adv)
		begin
			pc <= pc_d;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/fetch_pkg.sv
design/imem_loader.sv
design/pc_select.sv
design/instr_mem.sv
design/if_id_reg.sv
design/fetch_top.sv
tests/fetch_properties.sv
tests/fetch_tb.sv

/* tests/fetch_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_properties
(
	input wire                clk,
	input wire                rst_n,
	input wire                debug_flag,
	input wire                stall,
	input fetch_pkg::pc_src_e pc_src,
	input fetch_pkg::word_t   pc,
	input fetch_pkg::word_t   instr,
	input wire                halted
);

	// Edge on which the pc advances
	logic adv;

	// Failed assertions for the closing count
	int fail_cnt = 0;

	assign adv = !debug_flag && !stall && !halted;

	// No halt survives a reset
	halt_clear_after_reset: assert property (
		@(posedge clk) !rst_n |=> !halted
	) else
	begin
		fail_cnt++;
		$error("halted high on the cycle after reset");
	end

	// A halted stage keeps its pc
	pc_frozen_when_halted: assert property (
		@(posedge clk) disable iff (!rst_n)
		(halted && !debug_flag) |=> $stable(pc)
	) else
	begin
		fail_cnt++;
		$error("pc moved while the stage was halted");
	end

	// Redirect squashes the word fetched at the old pc
	nop_after_redirect: assert property (
		@(posedge clk) disable iff (!rst_n)
		(adv && (pc_src != fetch_pkg::PC_SEQ)) |=> (instr == `NOP_WORD)
	) else
	begin
		fail_cnt++;
		$error("instr is not a NOP after a redirect");
	end

endmodule

bind fetch_top fetch_properties fetch_properties_i (.*);

`default_nettype wire

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;

	localparam int MAX_CYCLES = 2000;
	localparam int PROG_LEN   = 40;

	logic               clk;
	logic               rst_n;
	logic               debug_flag;
	logic               load_strobe;
	fetch_pkg::word_t   load_word;
	fetch_pkg::pc_src_e pc_src;
	fetch_pkg::word_t   pc_jump;
	fetch_pkg::word_t   pc_branch;
	fetch_pkg::word_t   pc_register;
	logic               stall;
	fetch_pkg::word_t   instr;
	fetch_pkg::word_t   pc_next;
	fetch_pkg::word_t   pc;
	logic               halted;

	integer seed;
	int     err_cnt   = 0;
	int     check_cnt = 0;
	int     cycle_cnt = 0;

	// Program image and model state
	fetch_pkg::word_t         prog [0:PROG_LEN-1];
	fetch_pkg::word_t         m_mem [0:`IMEM_DEPTH-1];
	fetch_pkg::imem_addr_t    m_load_cnt;
	fetch_pkg::word_t         m_pc;
	fetch_pkg::word_t         m_instr;
	fetch_pkg::word_t         m_pc_next;
	logic                     m_halted;
	logic [2*`FETCH_XLEN-1:0] fetch_pair;

	fetch_top fetch_top_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.debug_flag  (debug_flag),
		.load_strobe (load_strobe),
		.load_word   (load_word),
		.pc_src      (pc_src),
		.pc_jump     (pc_jump),
		.pc_branch   (pc_branch),
		.pc_register (pc_register),
		.stall       (stall),
		.instr       (instr),
		.pc_next     (pc_next),
		.pc          (pc),
		.halted      (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////
	// Reference model
	////////////////////

	// {instr, pc_next} after the coming edge
	function automatic logic [2*`FETCH_XLEN-1:0] predict_fetch
	(
		input fetch_pkg::word_t   pc_v,
		input fetch_pkg::pc_src_e src,
		input logic               stall_v,
		input fetch_pkg::word_t   instr_v,
		input fetch_pkg::word_t   pc_next_v
	);
		logic [2*`FETCH_XLEN-1:0] res;
		if (stall_v)
			res = {instr_v, pc_next_v};
		else if (src != fetch_pkg::PC_SEQ)
			res = {`NOP_WORD, {`FETCH_XLEN{1'b0}}};
		else
			res = {m_mem[pc_v[`IMEM_AW-1:0]], pc_v + `FETCH_XLEN'd1};
		return res;
	endfunction

	function automatic fetch_pkg::word_t target_pc
	(
		input fetch_pkg::word_t   pc_v,
		input fetch_pkg::pc_src_e src
	);
		fetch_pkg::word_t res;
		case (src)
			fetch_pkg::PC_JUMP:     res = pc_jump;
			fetch_pkg::PC_BRANCH:   res = pc_branch;
			fetch_pkg::PC_REGISTER: res = pc_register;
			default:                res = pc_v + `FETCH_XLEN'd1;
		endcase
		return res;
	endfunction

	task automatic check_word(input string name, input fetch_pkg::word_t got,
		input fetch_pkg::word_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("MISMATCH %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_cnt);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("MISMATCH %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_cnt);
		end
	endtask

	// Outputs are stable at the falling edge and inputs hold until the next rising one
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			m_load_cnt = '0;
			m_pc       = '0;
			m_instr    = `NOP_WORD;
			m_pc_next  = '0;
			m_halted   = 1'b0;
		end
		else
		begin
			check_word("instr", instr, debug_flag ? `NOP_WORD : m_instr);
			check_word("pc_next", pc_next, m_pc_next);
			check_word("pc", pc, m_pc);
			check_flag("halted", halted, debug_flag ? 1'b0 : m_halted);
			if (debug_flag)
			begin
				if (load_strobe)
				begin
					m_mem[m_load_cnt] = load_word;
					m_load_cnt        = m_load_cnt + 1'b1;
				end
				m_pc      = '0;
				m_instr   = `NOP_WORD;
				m_pc_next = '0;
				m_halted  = 1'b0;
			end
			else
			begin
				m_load_cnt = '0;
				if (!m_halted)
				begin
					fetch_pair = predict_fetch(m_pc, pc_src, stall, m_instr, m_pc_next);
					if (!stall)
						m_pc = target_pc(m_pc, pc_src);
					m_instr   = fetch_pair[2*`FETCH_XLEN-1:`FETCH_XLEN];
					m_pc_next = fetch_pair[`FETCH_XLEN-1:0];
					m_halted  = (m_instr === `HALT_WORD);
				end
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic fill_program(input logic with_halt);
		fetch_pkg::word_t w;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			w = $random(seed);
			while (w == `HALT_WORD)
				w = $random(seed);
			prog[i] = w;
		end
		if (with_halt)
			prog[PROG_LEN-1] = `HALT_WORD;
	endtask

	task automatic enter_debug();
		@(posedge clk);
		debug_flag  <= 1'b1;
		load_strobe <= 1'b0;
		pc_src      <= fetch_pkg::PC_SEQ;
		stall       <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++)
		begin
			@(posedge clk);
			load_strobe <= 1'b1;
			load_word   <= prog[i];
		end
		@(posedge clk);
		load_strobe <= 1'b0;
		debug_flag  <= 1'b0;
	endtask

	task automatic run_sequential(input int n);
		repeat (n)
		begin
			@(posedge clk);
			pc_src <= fetch_pkg::PC_SEQ;
			stall  <= 1'b0;
		end
	endtask

	// Unselected targets differ so that a wrong choice shows up
	task automatic redirect(input fetch_pkg::pc_src_e src, input fetch_pkg::word_t target);
		@(posedge clk);
		pc_src      <= src;
		stall       <= 1'b0;
		pc_jump     <= (src == fetch_pkg::PC_JUMP) ? target : target + 32'd3;
		pc_branch   <= (src == fetch_pkg::PC_BRANCH) ? target : target + 32'd5;
		pc_register <= (src == fetch_pkg::PC_REGISTER) ? target : target + 32'd9;
		@(posedge clk);
		pc_src <= fetch_pkg::PC_SEQ;
	endtask

	task automatic run_stalls(input int n);
		logic [31:0] r;
		repeat (n)
		begin
			@(posedge clk);
			r = $random(seed);
			stall  <= r[0];
			pc_src <= fetch_pkg::PC_SEQ;
		end
		@(posedge clk);
		stall <= 1'b0;
	endtask

	task automatic wait_for_halt();
		do
			@(negedge clk);
		while (halted !== 1'b1);
	endtask

	initial
	begin
		seed        = 32'h4495_bc3c;
		rst_n       = 1'b0;
		debug_flag  = 1'b1;
		load_strobe = 1'b0;
		load_word   = '0;
		pc_src      = fetch_pkg::PC_SEQ;
		pc_jump     = '0;
		pc_branch   = '0;
		pc_register = '0;
		stall       = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Load and plain sequential fetch
		fill_program(1'b1);
		enter_debug();
		load_program();
		run_sequential(20);

		redirect(fetch_pkg::PC_JUMP, 32'd5);
		run_sequential(4);
		redirect(fetch_pkg::PC_BRANCH, 32'd12);
		run_sequential(4);
		redirect(fetch_pkg::PC_REGISTER, 32'd3);
		run_sequential(4);

		redirect(fetch_pkg::PC_JUMP, 32'd2);
		run_stalls(25);
		run_sequential(3);

		// Halt word sits in the last program slot
		redirect(fetch_pkg::PC_BRANCH, 32'd34);
		wait_for_halt();
		check_word("instr", instr, `HALT_WORD);
		check_word("pc", pc, fetch_pkg::word_t'(PROG_LEN));
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			pc_src  <= (i % 2 == 0) ? fetch_pkg::PC_JUMP : fetch_pkg::PC_REGISTER;
			pc_jump <= fetch_pkg::word_t'(i);
		end
		@(negedge clk);
		check_word("pc", pc, fetch_pkg::word_t'(PROG_LEN));
		check_word("instr", instr, `HALT_WORD);
		check_flag("halted", halted, 1'b1);

		// Debug re-entry with a fresh program
		enter_debug();
		@(negedge clk);
		check_flag("halted", halted, 1'b0);
		check_word("pc", pc, '0);
		fill_program(1'b0);
		load_program();
		run_sequential(30);
		@(negedge clk);

		$display("Error count: %0d in %0d checks, %0d assertion failures",
			err_cnt, check_cnt, fetch_top_i.fetch_properties_i.fail_cnt);
		if (err_cnt == 0 && fetch_top_i.fetch_properties_i.fail_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
